//--- hdl/pp_pkg.sv
// pixel staging package: bus widths plus the write beat and pixel stream structs
package pp_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  localparam int DATA_W = 8;             // one pixel byte
  localparam int ADDR_W = 10;            // per-bank address
  localparam int DEPTH  = 1 << ADDR_W;   // words per bank, 1024

  //////////////////////////////
  // write side
  //////////////////////////////

  // incoming beat from the pixel source, 9 bits
  typedef struct packed {
    logic [DATA_W-1:0] data;  // pixel byte
    logic              vld;   // high one cycle per beat
  } pp_wr_s;

  //////////////////////////////
  // read side
  //////////////////////////////

  // outgoing pixel towards the conv engine, 11 bits
  typedef struct packed {
    logic [DATA_W-1:0] data;        // pixel byte from the read bank
    logic              vld;         // one pixel per cycle while high
    logic              last_col;    // last pixel of a row
    logic              last_frame;  // last pixel of the frame
  } pp_pix_s;

  // frame size is IMG_W * IMG_H and must fit in DEPTH
  // both banks share DATA_W / ADDR_W
  // no back-pressure on either side
  // strobes and levels only

endpackage

//--- hdl/input_pre_sram.sv
// single-port bank memory with chip select, write enable and a registered read port
`timescale 1ns/1ns

module input_pre_sram (
  input  logic                      i_clk_input,  // bank clock
  input  logic                      i_cs,         // chip select
  input  logic                      i_we,         // 1 write, 0 read
  input  logic [pp_pkg::ADDR_W-1:0] i_addr,       // word address
  input  logic [pp_pkg::DATA_W-1:0] i_din,        // write data
  output logic [pp_pkg::DATA_W-1:0] o_dout        // read data, one cycle late
);

  //////////////////////////////
  // storage
  //////////////////////////////

  logic [pp_pkg::DATA_W-1:0] mem [pp_pkg::DEPTH];  // 1024 x 8

  //////////////////////////////
  // access port
  //////////////////////////////

  // one access per edge, write has the port when both would apply
  always_ff @(posedge i_clk_input) begin
    if (i_cs) begin
      if (i_we) begin
        mem[i_addr] <= i_din;   // write cycle
      end else begin
        o_dout <= mem[i_addr];  // registered read
      end
    end
  end

  // o_dout holds its last value while deselected
  // or while a write is in progress
  // no reset on the array or on the read register
  // contents are undefined until written

endmodule

//--- hdl/pingpong_buffer.sv
// two-bank ping-pong store: write counter, frame-full flag, swap acceptance and read steering
`timescale 1ns/1ns

module pingpong_buffer #(
  parameter int FRAME_SIZE = 32  // pixels per frame, set from the top
) (
  input  logic                      i_clk_input,  // system clock
  input  logic                      i_rst_n,      // sync reset, active low
  input  pp_pkg::pp_wr_s            i_wr,         // incoming write beat
  input  logic                      i_swap,       // swap request pulse
  input  logic                      i_rd_busy,    // reader still sweeping
  input  logic [pp_pkg::ADDR_W-1:0] i_rd_addr,    // reader address
  output logic                      o_full,       // write bank holds a frame
  output logic                      o_swapped,    // swap accepted last edge
  output logic [pp_pkg::DATA_W-1:0] o_rd_data     // data for last edge's address
);

  localparam int CNT_W = pp_pkg::ADDR_W + 1;  // must reach 1024

  //////////////////////////////
  // declarations
  //////////////////////////////

  logic                      bank_q;      // write bank, read bank is the other
  logic [CNT_W-1:0]          wr_cnt_q;    // bytes stored in write bank
  logic                      full_q;      // frame-full level
  logic                      swapped_q;   // accepted swap, delayed one
  logic                      rd_bank_q;   // bank sampled at last read edge

  logic                      wr_en;       // beat lands in the bank
  logic                      wr_last;     // beat completes the frame
  logic                      swap_acc;    // swap taken this edge
  logic [pp_pkg::ADDR_W-1:0] wr_addr;     // write pointer

  logic                      sram0_cs;
  logic                      sram0_we;
  logic [pp_pkg::ADDR_W-1:0] sram0_addr;
  logic [pp_pkg::DATA_W-1:0] sram0_dout;
  logic                      sram1_cs;
  logic                      sram1_we;
  logic [pp_pkg::ADDR_W-1:0] sram1_addr;
  logic [pp_pkg::DATA_W-1:0] sram1_dout;

  //////////////////////////////
  // write side
  //////////////////////////////

  assign wr_en    = i_wr.vld & (wr_cnt_q < CNT_W'(FRAME_SIZE));   // drop once full
  assign wr_last  = wr_en & (wr_cnt_q == CNT_W'(FRAME_SIZE - 1)); // final byte
  assign swap_acc = i_swap & ~i_rd_busy;                         // lost while reading
  assign wr_addr  = wr_cnt_q[pp_pkg::ADDR_W-1:0];

  always_ff @(posedge i_clk_input) begin
    if (!i_rst_n) begin
      bank_q    <= 1'b0;      // write into bank 0 first
      wr_cnt_q  <= '0;
      full_q    <= 1'b0;
      swapped_q <= 1'b0;
    end else begin
      swapped_q <= swap_acc;  // one-cycle start for the reader
      if (swap_acc) begin
        bank_q   <= ~bank_q;  // exchange roles
        wr_cnt_q <= '0;       // fresh frame
        full_q   <= 1'b0;
      end else begin
        if (wr_en) begin
          wr_cnt_q <= wr_cnt_q + 1'b1;
        end
        if (wr_last) begin
          full_q <= 1'b1;     // held until next accepted swap
        end
      end
    end
  end

  //////////////////////////////
  // bank steering
  //////////////////////////////

  // write bank gets the counter, read bank gets the reader address
  always_comb begin
    if (!bank_q) begin
      sram0_cs   = wr_en;
      sram0_we   = wr_en;
      sram0_addr = wr_addr;
      sram1_cs   = i_rd_busy;  // read only while sweeping
      sram1_we   = 1'b0;
      sram1_addr = i_rd_addr;
    end else begin
      sram0_cs   = i_rd_busy;
      sram0_we   = 1'b0;
      sram0_addr = i_rd_addr;
      sram1_cs   = wr_en;
      sram1_we   = wr_en;
      sram1_addr = wr_addr;
    end
  end

  // remember which bank the last read went to, survives a swap edge
  always_ff @(posedge i_clk_input) begin
    if (!i_rst_n) begin
      rd_bank_q <= 1'b1;       // bank 1 is read side after reset
    end else begin
      rd_bank_q <= ~bank_q;
    end
  end

  //////////////////////////////
  // banks
  //////////////////////////////

  input_pre_sram sram0 (
    .i_clk_input (i_clk_input),
    .i_cs        (sram0_cs),
    .i_we        (sram0_we),
    .i_addr      (sram0_addr),
    .i_din       (i_wr.data),  // shared write data
    .o_dout      (sram0_dout)
  );

  input_pre_sram sram1 (
    .i_clk_input (i_clk_input),
    .i_cs        (sram1_cs),
    .i_we        (sram1_we),
    .i_addr      (sram1_addr),
    .i_din       (i_wr.data),
    .o_dout      (sram1_dout)
  );

  assign o_rd_data = rd_bank_q ? sram1_dout : sram0_dout;  // matching bank
  assign o_full    = full_q;
  assign o_swapped = swapped_q;

endmodule

//--- hdl/conv_frame_reader.sv
// raster sweep of the read bank into a pixel stream with row and frame markers
`timescale 1ns/1ns

module conv_frame_reader #(
  parameter int IMG_W = 8,  // pixels per row
  parameter int IMG_H = 4   // rows per frame
) (
  input  logic                      i_clk_input,  // system clock
  input  logic                      i_rst_n,      // sync reset, active low
  input  logic                      i_start,      // swap accepted, begin sweep
  input  logic [pp_pkg::DATA_W-1:0] i_rd_data,    // bank data, one cycle late
  output logic [pp_pkg::ADDR_W-1:0] o_rd_addr,    // raster address
  output logic                      o_busy,       // sweep or pipeline active
  output pp_pkg::pp_pix_s           o_pix         // pixel stream
);

  localparam int COL_W = (IMG_W > 1) ? $clog2(IMG_W) : 1;
  localparam int ROW_W = (IMG_H > 1) ? $clog2(IMG_H) : 1;

  //////////////////////////////
  // declarations
  //////////////////////////////

  logic [COL_W-1:0]          col_q;           // column of current address
  logic [ROW_W-1:0]          row_q;           // row of current address
  logic [pp_pkg::ADDR_W-1:0] addr_q;          // linear address, 0 when idle
  logic                      sweep_q;         // addresses 1..N-1 in flight
  logic                      act;             // address valid this cycle
  logic                      end_col;
  logic                      end_frame;
  logic                      s1_vld_q;        // lines up with sram dout
  logic                      s1_last_col_q;
  logic                      s1_last_frame_q;
  logic                      pix_vld_q;       // output stage
  logic                      pix_last_col_q;
  logic                      pix_last_frame_q;
  logic [pp_pkg::DATA_W-1:0] pix_data_q;

  assign act       = i_start | sweep_q;                        // addr 0 on start
  assign end_col   = (col_q == COL_W'(IMG_W - 1));
  assign end_frame = end_col & (row_q == ROW_W'(IMG_H - 1));

  //////////////////////////////
  // address generator
  //////////////////////////////

  always_ff @(posedge i_clk_input) begin
    if (!i_rst_n) begin
      sweep_q <= 1'b0;
      col_q   <= '0;
      row_q   <= '0;
      addr_q  <= '0;
    end else if (act) begin
      if (end_frame) begin
        sweep_q <= 1'b0;            // last address issued
        col_q   <= '0;
        row_q   <= '0;
        addr_q  <= '0;              // park at 0 for next start
      end else begin
        sweep_q <= 1'b1;
        addr_q  <= addr_q + 1'b1;   // raster order
        if (end_col) begin
          col_q <= '0;
          row_q <= row_q + 1'b1;    // wrap to next row
        end else begin
          col_q <= col_q + 1'b1;
        end
      end
    end
  end

  //////////////////////////////
  // marker pipeline
  //////////////////////////////

  always_ff @(posedge i_clk_input) begin
    if (!i_rst_n) begin
      s1_vld_q         <= 1'b0;
      s1_last_col_q    <= 1'b0;
      s1_last_frame_q  <= 1'b0;
      pix_vld_q        <= 1'b0;
      pix_last_col_q   <= 1'b0;
      pix_last_frame_q <= 1'b0;
    end else begin
      s1_vld_q         <= act;              // sram read happens this edge
      s1_last_col_q    <= act & end_col;
      s1_last_frame_q  <= act & end_frame;
      pix_vld_q        <= s1_vld_q;         // into output register
      pix_last_col_q   <= s1_last_col_q;
      pix_last_frame_q <= s1_last_frame_q;
    end
  end

  always_ff @(posedge i_clk_input) begin
    pix_data_q <= i_rd_data;  // payload, follows the flags
  end

  assign o_rd_addr = addr_q;
  assign o_busy    = act | s1_vld_q | pix_vld_q;  // drops after final pixel
  assign o_pix     = '{data:       pix_data_q,
                       vld:        pix_vld_q,
                       last_col:   pix_last_col_q,
                       last_frame: pix_last_frame_q};

endmodule

//--- hdl/pp_top.sv
// input staging top: ping-pong pixel buffer feeding the raster frame reader
`timescale 1ns/1ns

module pp_top #(
  parameter int IMG_W = 8,  // frame width in pixels
  parameter int IMG_H = 4   // frame height in rows
) (
  input  logic            i_clk_input,  // system clock
  input  logic            i_rst_n,      // sync reset, active low
  input  pp_pkg::pp_wr_s  i_wr,         // write beat
  input  logic            i_swap,       // swap request pulse
  output logic            o_full,       // write bank full
  output logic            o_busy,       // reader active
  output pp_pkg::pp_pix_s o_pix         // pixel stream
);

  //////////////////////////////
  // internal wires
  //////////////////////////////

  logic                      swapped;  // buffer to reader start
  logic                      rd_busy;  // reader back to buffer
  logic [pp_pkg::ADDR_W-1:0] rd_addr;
  logic [pp_pkg::DATA_W-1:0] rd_data;

  assign o_busy = rd_busy;

  pingpong_buffer #(
    .FRAME_SIZE (IMG_W * IMG_H)  // must not exceed 1024
  ) buf0 (
    .i_clk_input (i_clk_input),
    .i_rst_n     (i_rst_n),
    .i_wr        (i_wr),
    .i_swap      (i_swap),
    .i_rd_busy   (rd_busy),
    .i_rd_addr   (rd_addr),
    .o_full      (o_full),
    .o_swapped   (swapped),
    .o_rd_data   (rd_data)
  );

  conv_frame_reader #(
    .IMG_W (IMG_W),
    .IMG_H (IMG_H)
  ) rdr0 (
    .i_clk_input (i_clk_input),
    .i_rst_n     (i_rst_n),
    .i_start     (swapped),
    .i_rd_data   (rd_data),
    .o_rd_addr   (rd_addr),
    .o_busy      (rd_busy),
    .o_pix       (o_pix)
  );

endmodule

//--- verification/pp_checker.sv
// stream and flag checker comparing pixels, markers and levels with the expected frames
`timescale 1ns/1ns

module pp_checker #(
  parameter int IMG_W = 8,
  parameter int IMG_H = 4
) (
  input logic            i_clk_input,
  input logic            i_rst_n,
  input pp_pkg::pp_pix_s i_pix,
  input logic            i_full,
  input logic            i_busy
);

  localparam int FRAME = IMG_W * IMG_H;

  logic [pp_pkg::DATA_W-1:0] exp_q [$];  // expected bytes of queued frames
  int                        id_q [$];   // test owning each queued frame
  int                        test_errs [64];
  int                        pix_idx   = 0;
  int                        err_cnt   = 0;
  int                        tests_run = 0;
  int                        tests_bad = 0;

  task automatic compare(input int id, input string name, input logic [7:0] got,
                         input logic [7:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s in test %0d: got %h expected %h", name, id, got, exp);
      err_cnt++;
      test_errs[id]++;
    end
  endtask

  task automatic finish_test(input int id);
    tests_run++;
    if (test_errs[id] != 0) begin
      tests_bad++;
      $display("test %0d failed with %0d errors", id, test_errs[id]);
    end else begin
      $display("test %0d passed", id);
    end
  endtask

  task automatic check_levels(input int id, input logic exp_full, input logic chk_busy,
                              input logic exp_busy, input logic last);
    compare(id, "o_full", 8'(i_full), 8'(exp_full));
    if (chk_busy) begin
      compare(id, "o_busy", 8'(i_busy), 8'(exp_busy));
    end
    if (last) begin
      finish_test(id);
    end
  endtask

  task automatic finish_run();
    if (exp_q.size() != 0) begin
      $display("%0d expected pixels were never streamed", exp_q.size());
      err_cnt++;
    end
  endtask

  //////////////////////////////
  // stream monitor
  //////////////////////////////

  always @(negedge i_clk_input) begin
    int id;
    if (i_rst_n && i_pix.vld) begin
      if (id_q.size() == 0) begin
        $display("pixel valid with no frame expected, data %h", i_pix.data);
        err_cnt++;
      end else begin
        id = id_q[0];
        compare(id, "o_pix.data", i_pix.data, exp_q.pop_front());
        compare(id, "o_pix.last_col", 8'(i_pix.last_col),
                8'((pix_idx % IMG_W) == IMG_W - 1));
        compare(id, "o_pix.last_frame", 8'(i_pix.last_frame),
                8'(pix_idx == FRAME - 1));
        pix_idx++;
        if (pix_idx == FRAME) begin
          pix_idx = 0;
          void'(id_q.pop_front());
          finish_test(id);
        end
      end
    end else if (i_rst_n && pix_idx != 0) begin
      id = id_q.pop_front();
      $display("pixel stream broke off after %0d of %0d pixels in test %0d",
               pix_idx, FRAME, id);
      err_cnt++;
      test_errs[id]++;
      repeat (FRAME - pix_idx) void'(exp_q.pop_front());  // drop rest of frame
      pix_idx = 0;
      finish_test(id);
    end
  end

endmodule

//--- verification/pp_assert.sv
// protocol assertions on the staging top: valid, frame marker and full flag rules
`timescale 1ns/1ns

module pp_assert (
  input logic            i_clk_input,
  input logic            i_rst_n,
  input pp_pkg::pp_pix_s i_pix,
  input logic            i_busy,
  input logic            i_full,
  input logic            i_swapped
);

  int unsigned fail_cnt = 0;  // failed checks so far

  vld_in_sweep: assert property (@(posedge i_clk_input) disable iff (!i_rst_n)
    !i_busy |-> !i_pix.vld)
    else begin
      fail_cnt++;
      $error("pixel valid while reader idle");
    end

  frame_mark_with_vld: assert property (@(posedge i_clk_input) disable iff (!i_rst_n)
    i_pix.last_frame |-> i_pix.vld)
    else begin
      fail_cnt++;
      $error("last_frame without valid pixel");
    end

  // accepted swap shows as the start pulse one cycle later
  full_falls_on_swap: assert property (@(posedge i_clk_input) disable iff (!i_rst_n)
    $fell(i_full) |-> i_swapped)
    else begin
      fail_cnt++;
      $error("o_full dropped without an accepted swap");
    end

endmodule

bind pp_top pp_assert prop0 (
  .i_clk_input (i_clk_input),
  .i_rst_n     (i_rst_n),
  .i_pix       (o_pix),
  .i_busy      (o_busy),
  .i_full      (o_full),
  .i_swapped   (swapped)
);

//--- verification/tb_top.sv
// testbench top with clock, reset, test file replay, stimulus, watchdog and summary
`timescale 1ns/1ns

module tb_top;

  localparam int IMG_W = 8;
  localparam int IMG_H = 4;
  localparam int FRAME = IMG_W * IMG_H;
  localparam int NCOL  = 5;                     // words per test line

  logic                      clk = 1'b0;
  logic                      rst_n;
  pp_pkg::pp_wr_s            wr;
  logic                      swap;
  logic                      full;
  logic                      busy;
  pp_pkg::pp_pix_s           pix;
  logic [31:0]               tests [64*NCOL];   // kind, bytes, start, step, swap in read
  logic [pp_pkg::DATA_W-1:0] model_q [$];       // bytes the write bank should hold
  int                        ntests;
  int                        limit_cycles = 0;

  always #10 clk = ~clk;  // 20 ns period

  pp_top #(.IMG_W(IMG_W), .IMG_H(IMG_H)) dut0 (
    .i_clk_input (clk),
    .i_rst_n     (rst_n),
    .i_wr        (wr),
    .i_swap      (swap),
    .o_full      (full),
    .o_busy      (busy),
    .o_pix       (pix)
  );

  pp_checker #(.IMG_W(IMG_W), .IMG_H(IMG_H)) chk0 (
    .i_clk_input (clk),
    .i_rst_n     (rst_n),
    .i_pix       (pix),
    .i_full      (full),
    .i_busy      (busy)
  );

  //////////////////////////////
  // driving
  //////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #2;                                         // inputs move just after the edge
  endtask

  task automatic wait_idle();
    @(negedge clk);
    while (busy) begin
      @(negedge clk);
    end
    next_cycle();
  endtask

  task automatic pulse_swap();
    swap = 1'b1;
    next_cycle();
    swap = 1'b0;
  endtask

  task automatic write_bytes(input int n, input logic [7:0] start, input logic [7:0] step);
    logic [7:0] b;
    for (int i = 0; i < n; i++) begin
      b = start + 8'(i) * step;                 // wraps mod 256
      repeat ($urandom % 4) next_cycle();       // idle gap 0..3
      wr = '{data: b, vld: 1'b1};
      if (model_q.size() < FRAME) begin
        model_q.push_back(b);                   // dropped once a frame is held
      end
      next_cycle();
      wr.vld = 1'b0;
    end
  endtask

  task automatic run_test(input int t);
    logic full_exp;
    if (tests[t*NCOL] == 2) begin
      wait_idle();
      rst_n = 1'b0;
      repeat (4) next_cycle();
      rst_n = 1'b1;
      model_q.delete();                         // fresh start
      @(negedge clk);
      chk0.check_levels(t, 1'b0, 1'b1, 1'b0, 1'b1);
      next_cycle();
    end else begin
      write_bytes(tests[t*NCOL+1], tests[t*NCOL+2][7:0], tests[t*NCOL+3][7:0]);
      full_exp = (model_q.size() == FRAME);
      @(negedge clk);
      chk0.check_levels(t, full_exp, 1'b0, 1'b0, !full_exp);  // closes test if no stream
      next_cycle();
      if (full_exp) begin
        wait_idle();                            // earlier frame must be out
        foreach (model_q[i]) begin
          chk0.exp_q.push_back(model_q[i]);
        end
        chk0.id_q.push_back(t);
        model_q.delete();
        pulse_swap();
        if (tests[t*NCOL+4][0]) begin
          repeat (3) next_cycle();
          pulse_swap();                         // reader busy so the pulse is lost
          @(negedge clk);
          chk0.check_levels(t, 1'b0, 1'b1, 1'b1, 1'b0);
          next_cycle();
        end
      end
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    rst_n = 1'b0;
    wr    = '0;
    swap  = 1'b0;
    void'($urandom(32'he6d8));
    foreach (tests[i]) begin
      tests[i] = '1;                            // end marker
    end
    $readmemh("verification/pp_tests.txt", tests);
    ntests = 0;
    while (ntests < 64 && tests[ntests*NCOL] != '1) begin
      ntests++;
    end
    limit_cycles = ntests * (1024 * 5 + 200);
    repeat (4) next_cycle();                    // 4 cycles of reset
    rst_n = 1'b1;
    for (int t = 0; t < ntests; t++) begin
      run_test(t);
    end
    wait_idle();
    repeat (8) next_cycle();                    // room for a stray stream
    chk0.finish_run();
    $display("%0d of %0d tests run, %0d passed, %0d failed, %0d assertion failures",
             chk0.tests_run, ntests, chk0.tests_run - chk0.tests_bad, chk0.tests_bad,
             dut0.prop0.fail_cnt);
    if (ntests == 0) begin
      $display("no tests were found in the test file");
    end
    if (chk0.tests_run != ntests) begin
      $display("only %0d of %0d tests finished", chk0.tests_run, ntests);
    end
    if (ntests > 0 && chk0.tests_run == ntests && chk0.tests_bad == 0 &&
        chk0.err_cnt == 0 && dut0.prop0.fail_cnt == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("simulation timed out after %0d cycles", limit_cycles);
    $display("tests failed");
    $finish;
  end

endmodule

//--- verification/pp_tests.txt
// columns, all hex: kind nbytes start step swap_in_read
// kind 1 writes nbytes and swaps once a frame is held, kind 2 applies reset
1 20 00 01 0   // full frame, ramp
1 20 80 03 0   // written while the previous frame streams
1 10 40 05 0   // partial fill, o_full stays low
2 00 00 00 0   // reset drops the partial frame
1 28 10 07 0   // overfill, last 8 bytes dropped
1 20 c3 fd 1   // swap pulse during the read is lost
1 20 55 0b 0   // next frame after the lost swap
1 0c 21 11 0   // partial again
1 20 9a 02 0   // completes the partial frame, 12 bytes dropped
2 00 00 00 0   // final reset

//--- tb.f
hdl/pp_pkg.sv
hdl/input_pre_sram.sv
hdl/pingpong_buffer.sv
hdl/conv_frame_reader.sv
hdl/pp_top.sv
verification/pp_checker.sv
verification/pp_assert.sv
verification/tb_top.sv

//--- Makefile
# Verilator flow for the pixel staging testbench
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module tb_top

sim:
	verilator --binary --timing --assert -f tb.f --top-module tb_top -o tb_sim
	./obj_dir/tb_sim +verilator+error+limit+1000 > $(LOG) 2>&1; rc=$$?; \
	cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "tests failed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
